// ==== Bender.yml ====
package:
  name: dcache

sources:
  - dcache_geom_pkg.sv
  - dcache_bus_pkg.sv
  - dcache_req_buffer.sv
  - dcache_way_array.sv
  - dcache_ctrl.sv
  - dcache.sv
  - target: test
    files:
      - tb_dcache.sv

// ==== compile.f ====
dcache_geom_pkg.sv
dcache_bus_pkg.sv
dcache_req_buffer.sv
dcache_way_array.sv
dcache_ctrl.sv
dcache.sv
tb_dcache.sv

// ==== dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  logic                               clk,
    input  logic                               reset,
    // load/store pipeline
    input  logic                               req_valid,
    output logic                               req_ready,
    input  dcache_bus_pkg::req_kind_t          req_kind,
    input  dcache_bus_pkg::word_t              req_addr,
    input  dcache_bus_pkg::word_t              req_wdata,
    input  dcache_bus_pkg::strb_t              req_wstrb,
    output logic                               resp_valid,
    output dcache_bus_pkg::word_t              resp_rdata,
    // line-wide memory port
    output logic                               mem_req,
    output logic                               mem_wr,
    output dcache_bus_pkg::word_t              mem_addr,
    output dcache_bus_pkg::word_t              mem_wdata,
    output dcache_bus_pkg::strb_t              mem_wstrb,
    input  logic                               mem_addr_ok,
    input  dcache_geom_pkg::line_t             mem_rdata,
    input  logic                               mem_data_ok
);

    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    logic            load;
    index_t          read_index;
    req_kind_t       held_kind;
    tag_t            held_tag;
    index_t          held_index;
    offset_t         held_offset;
    word_t           held_word_addr;
    word_t           held_wdata;
    strb_t           held_wstrb;
    tag_t            tag_entries [WAYS];
    line_t           line_entries [WAYS];
    logic [WAYS-1:0] tag_we;
    logic [WAYS-1:0] data_we;
    index_t          array_write_index;
    tag_t            tag_write;
    line_t           line_write;

    //////////////////////////////
    // decode
    //////////////////////////////

    dcache_req_buffer req_buffer_inst (
        .clk            (clk),
        .reset          (reset),
        .load           (load),
        .kind           (req_kind),
        .addr           (req_addr),
        .wdata          (req_wdata),
        .wstrb          (req_wstrb),
        .read_index     (read_index),
        .held_kind      (held_kind),
        .held_tag       (held_tag),
        .held_index     (held_index),
        .held_offset    (held_offset),
        .held_word_addr (held_word_addr),
        .held_wdata     (held_wdata),
        .held_wstrb     (held_wstrb)
    );

    //////////////////////////////
    // arrays and controller
    //////////////////////////////

    dcache_way_array #(.entry_t(tag_t)) tag_array (
        .clk          (clk),
        .read_index   (read_index),
        .write_index  (array_write_index),
        .write_en     (tag_we),
        .write_entry  (tag_write),
        .read_entries (tag_entries)
    );

    dcache_way_array #(.entry_t(line_t)) data_array (
        .clk          (clk),
        .read_index   (read_index),
        .write_index  (array_write_index),
        .write_en     (data_we),
        .write_entry  (line_write),
        .read_entries (line_entries)
    );

    dcache_ctrl ctrl_inst (
        .clk               (clk),
        .reset             (reset),
        .req_valid         (req_valid),
        .held_kind         (held_kind),
        .held_tag          (held_tag),
        .held_index        (held_index),
        .held_offset       (held_offset),
        .held_word_addr    (held_word_addr),
        .held_wdata        (held_wdata),
        .held_wstrb        (held_wstrb),
        .tag_entries       (tag_entries),
        .line_entries      (line_entries),
        .mem_addr_ok       (mem_addr_ok),
        .mem_rdata         (mem_rdata),
        .mem_data_ok       (mem_data_ok),
        .req_ready         (req_ready),
        .load              (load),
        .resp_valid        (resp_valid),
        .resp_rdata        (resp_rdata),
        .tag_we            (tag_we),
        .data_we           (data_we),
        .array_write_index (array_write_index),
        .tag_write         (tag_write),
        .line_write        (line_write),
        .mem_req           (mem_req),
        .mem_wr            (mem_wr),
        .mem_addr          (mem_addr),
        .mem_wdata         (mem_wdata),
        .mem_wstrb         (mem_wstrb)
    );

endmodule

`default_nettype wire

// ==== dcache_bus_pkg.sv ====
`default_nettype none

package dcache_bus_pkg;

    //////////////////////////////
    // pipeline and memory words
    //////////////////////////////

    // one data word
    typedef logic [31:0] word_t;

    // one enable bit per byte lane, bit 0 is bits 7:0
    typedef logic [3:0] strb_t;

    // request kind, same coding as the load/store unit
    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_kind_t;

endpackage

`default_nettype wire

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req_valid,
    input  dcache_bus_pkg::req_kind_t          held_kind,
    input  dcache_geom_pkg::tag_t              held_tag,
    input  dcache_geom_pkg::index_t            held_index,
    input  dcache_geom_pkg::offset_t           held_offset,
    input  dcache_bus_pkg::word_t              held_word_addr,
    input  dcache_bus_pkg::word_t              held_wdata,
    input  dcache_bus_pkg::strb_t              held_wstrb,
    input  dcache_geom_pkg::tag_t              tag_entries [dcache_geom_pkg::WAYS],
    input  dcache_geom_pkg::line_t             line_entries [dcache_geom_pkg::WAYS],
    input  logic                               mem_addr_ok,
    input  dcache_geom_pkg::line_t             mem_rdata,
    input  logic                               mem_data_ok,
    output logic                               req_ready,
    output logic                               load,
    output logic                               resp_valid,
    output dcache_bus_pkg::word_t              resp_rdata,
    output logic [dcache_geom_pkg::WAYS-1:0]   tag_we,
    output logic [dcache_geom_pkg::WAYS-1:0]   data_we,
    output dcache_geom_pkg::index_t            array_write_index,
    output dcache_geom_pkg::tag_t              tag_write,
    output dcache_geom_pkg::line_t             line_write,
    output logic                               mem_req,
    output logic                               mem_wr,
    output dcache_bus_pkg::word_t              mem_addr,
    output dcache_bus_pkg::word_t              mem_wdata,
    output dcache_bus_pkg::strb_t              mem_wstrb
);

    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_LINE_REQ,
        S_LINE_WAIT,
        S_WORD_REQ,
        S_WORD_WAIT
    } state_t;

    state_t                        state;
    state_t                        state_next;
    logic [SETS-1:0][WAYS-1:0]     valid;
    logic [SETS-1:0][WAY_BITS-1:0] lru_victim;
    logic [WAYS-1:0]               hit;
    logic                          any_hit;
    logic [WAY_BITS-1:0]           hit_way;
    logic [WAY_BITS-1:0]           victim_way;
    logic [WAY_BITS-1:0]           touch_way;
    logic                          touch;
    logic                          fill;
    line_t                         hit_line;
    line_t                         merged_line;
    word_t                         line_addr;

    //////////////////////////////
    // hit and victim
    //////////////////////////////

    always_comb begin
        hit     = '0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit[w] = valid[held_index][w] && (tag_entries[w] == held_tag);
            if (hit[w]) begin
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign any_hit  = |hit;
    assign hit_line = line_entries[hit_way];

    // lowest invalid way first, else the LRU one
    always_comb begin
        victim_way = lru_victim[held_index];
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid[held_index][w]) begin
                victim_way = WAY_BITS'(w);
            end
        end
    end

    // store bytes merged into the hit line
    always_comb begin
        merged_line = hit_line;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (held_wstrb[b]) begin
                merged_line[held_offset][8*b +: 8] = held_wdata[8*b +: 8];
            end
        end
    end

    //////////////////////////////
    // FSM
    //////////////////////////////

    assign line_addr = {held_tag, held_index, {(OFFSET_WIDTH + BYTE_BITS){1'b0}}};

    always_comb begin
        state_next = state;
        req_ready  = 1'b0;
        load       = 1'b0;
        resp_valid = 1'b0;
        tag_we     = '0;
        data_we    = '0;
        line_write = mem_rdata;
        mem_req    = 1'b0;
        mem_wr     = 1'b0;
        mem_addr   = line_addr;
        touch      = 1'b0;
        touch_way  = hit_way;
        fill       = 1'b0;
        case (state)
            S_IDLE: begin
                req_ready = 1'b1;
                if (req_valid) begin
                    load       = 1'b1;
                    state_next = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (held_kind == REQ_READ) begin
                    if (any_hit) begin
                        resp_valid = 1'b1;
                        touch      = 1'b1;
                        state_next = S_IDLE;
                    end else begin
                        state_next = S_LINE_REQ;
                    end
                end else begin
                    // every store also goes out to memory
                    if (any_hit) begin
                        data_we[hit_way] = 1'b1;
                        line_write       = merged_line;
                        touch            = 1'b1;
                    end
                    state_next = S_WORD_REQ;
                end
            end
            S_LINE_REQ: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    state_next = S_LINE_WAIT;
                end
            end
            S_LINE_WAIT: begin
                if (mem_data_ok) begin
                    fill                = 1'b1;
                    tag_we[victim_way]  = 1'b1;
                    data_we[victim_way] = 1'b1;
                    touch               = 1'b1;
                    touch_way           = victim_way;
                    resp_valid          = 1'b1;
                    state_next          = S_IDLE;
                end
            end
            S_WORD_REQ: begin
                mem_req  = 1'b1;
                mem_wr   = 1'b1;
                mem_addr = held_word_addr;
                if (mem_addr_ok) begin
                    state_next = S_WORD_WAIT;
                end
            end
            S_WORD_WAIT: begin
                if (mem_data_ok) begin
                    resp_valid = 1'b1;
                    state_next = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    // two ways, so the victim is just the way not used last
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            valid      <= '0;
            lru_victim <= '0;
        end else begin
            state <= state_next;
            if (fill) begin
                valid[held_index][victim_way] <= 1'b1;
            end
            if (touch) begin
                lru_victim[held_index] <= ~touch_way;
            end
        end
    end

    assign array_write_index = held_index;
    assign tag_write         = held_tag;
    assign mem_wdata         = held_wdata;
    assign mem_wstrb         = mem_wr ? held_wstrb : '0;

    // result stage selects the word by offset
    assign resp_rdata = (state == S_LINE_WAIT) ? mem_rdata[held_offset] : hit_line[held_offset];

    //////////////////////////////
    // checks
    //////////////////////////////

    a_single_hit: assert property (
        @(posedge clk) disable iff (reset) state == S_LOOKUP |-> $onehot0(hit)
    ) else $error("dcache: tag found in two ways");

    a_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_addr) && $stable(mem_wr)
    ) else $error("dcache: memory request changed before mem_addr_ok");

    a_data_ok_expected: assert property (
        @(posedge clk) disable iff (reset)
        mem_data_ok |-> (state == S_LINE_WAIT || state == S_WORD_WAIT)
    ) else $error("dcache: mem_data_ok with no transfer outstanding");

endmodule

`default_nettype wire

// ==== dcache_geom_pkg.sv ====
`default_nettype none

package dcache_geom_pkg;

    //////////////////////////////
    // cache shape
    //////////////////////////////

    localparam int INDEX_WIDTH  = 4;
    localparam int OFFSET_WIDTH = 2;
    localparam int WAYS         = 2;

    // derived sizes
    localparam int SETS       = 1 << INDEX_WIDTH;
    localparam int LINE_WORDS = 1 << OFFSET_WIDTH;
    localparam int WAY_BITS   = (WAYS > 1) ? $clog2(WAYS) : 1;

    //////////////////////////////
    // address fields
    //////////////////////////////

    // byte address, 4 bytes per word
    localparam int WORD_BITS = 32;
    localparam int BYTE_BITS = 2;

    // tag takes whatever is left above index and offset
    localparam int TAG_WIDTH = WORD_BITS - INDEX_WIDTH - OFFSET_WIDTH - BYTE_BITS;

    typedef logic [INDEX_WIDTH-1:0]  index_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;
    typedef logic [TAG_WIDTH-1:0]    tag_t;

    // word 0 of the line sits in the low bits
    typedef logic [LINE_WORDS-1:0][WORD_BITS-1:0] line_t;

endpackage

`default_nettype wire

// ==== dcache_req_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_req_buffer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         load,
    input  dcache_bus_pkg::req_kind_t    kind,
    input  dcache_bus_pkg::word_t        addr,
    input  dcache_bus_pkg::word_t        wdata,
    input  dcache_bus_pkg::strb_t        wstrb,
    output dcache_geom_pkg::index_t      read_index,
    output dcache_bus_pkg::req_kind_t    held_kind,
    output dcache_geom_pkg::tag_t        held_tag,
    output dcache_geom_pkg::index_t      held_index,
    output dcache_geom_pkg::offset_t     held_offset,
    output dcache_bus_pkg::word_t        held_word_addr,
    output dcache_bus_pkg::word_t        held_wdata,
    output dcache_bus_pkg::strb_t        held_wstrb
);

    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    localparam int INDEX_LSB = OFFSET_WIDTH + BYTE_BITS;

    word_t held_addr;

    // incoming index goes straight to the arrays
    assign read_index = addr[INDEX_LSB +: INDEX_WIDTH];

    // held kind starts out as read
    always_ff @(posedge clk) begin
        if (reset) begin
            held_kind <= REQ_READ;
        end else if (load) begin
            held_kind <= kind;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            held_addr  <= addr;
            held_wdata <= wdata;
            held_wstrb <= wstrb;
        end
    end

    // split of the held address
    assign held_tag       = held_addr[WORD_BITS-1 -: TAG_WIDTH];
    assign held_index     = held_addr[INDEX_LSB +: INDEX_WIDTH];
    assign held_offset    = held_addr[BYTE_BITS +: OFFSET_WIDTH];
    assign held_word_addr = {held_addr[WORD_BITS-1:BYTE_BITS], {BYTE_BITS{1'b0}}};

endmodule

`default_nettype wire

// ==== dcache_way_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_way_array #(
    parameter type entry_t = logic
) (
    input  logic                           clk,
    input  dcache_geom_pkg::index_t        read_index,
    input  dcache_geom_pkg::index_t        write_index,
    input  logic [dcache_geom_pkg::WAYS-1:0] write_en,
    input  entry_t                         write_entry,
    output entry_t                         read_entries [dcache_geom_pkg::WAYS]
);

    import dcache_geom_pkg::*;

    // one bank of SETS entries per way
    entry_t store [WAYS][SETS];

    //////////////////////////////
    // write and registered read
    //////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (write_en[w]) begin
                store[w][write_index] <= write_entry;
            end
        end
    end

    // all ways read in parallel, data one cycle later
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            read_entries[w] <= store[w][read_index];
        end
    end

    // a fill or store hit only ever touches one way
    a_one_way_written: assert property (
        @(posedge clk) !$isunknown(write_en) |-> $onehot0(write_en)
    ) else $error("way array: several ways written in one cycle");

endmodule

`default_nettype wire

// ==== tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    localparam int MEM_WORDS     = 256;
    localparam int RANDOM_OPS    = 600;
    localparam int DIRECTED_OPS  = 20;
    localparam int CYCLES_PER_OP = 16;
    // worst case per request plus reset and slack
    localparam int TIMEOUT_CYCLES = (RANDOM_OPS + DIRECTED_OPS) * CYCLES_PER_OP + 2080;
    localparam int INDEX_LSB      = OFFSET_WIDTH + BYTE_BITS;

    logic      clk = 1'b0;
    logic      reset;
    logic      req_valid;
    logic      req_ready;
    req_kind_t req_kind;
    word_t     req_addr;
    word_t     req_wdata;
    strb_t     req_wstrb;
    logic      resp_valid;
    word_t     resp_rdata;
    logic      mem_req;
    logic      mem_wr;
    word_t     mem_addr;
    word_t     mem_wdata;
    strb_t     mem_wstrb;
    logic      mem_addr_ok;
    line_t     mem_rdata;
    logic      mem_data_ok;

    int    seed = 60;
    int    cycle_count = 0;
    int    line_reads;
    int    word_writes;
    word_t last_line_addr;
    word_t last_write_addr;
    word_t last_write_data;
    strb_t last_write_strb;

    // memory behind the cache, and the reference copy of it
    word_t model_mem [MEM_WORDS];
    word_t shadow_mem [MEM_WORDS];
    tag_t  shadow_tag [SETS][WAYS];
    logic  shadow_valid [SETS][WAYS];
    int    shadow_victim [SETS];

    always #2 clk = ~clk;

    dcache dcache_inst (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_kind    (req_kind),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wstrb   (req_wstrb),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_rdata   (mem_rdata),
        .mem_data_ok (mem_data_ok)
    );

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_hit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_mem_write(input word_t got_addr, input word_t got_data,
                                   input strb_t got_strb, input word_t exp_addr,
                                   input word_t exp_data, input strb_t exp_strb);
        check_word("mem_addr", got_addr, exp_addr);
        check_word("mem_wdata", got_data, exp_data);
        if (got_strb !== exp_strb) begin
            $display("ERR mem_wstrb: got %h expected %h", got_strb, exp_strb);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: cache still busy after %0d cycles", cycle_count);
            abort_run();
        end
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    // returns the word memory holds afterwards
    // fetch tells if a line read is due
    function automatic word_t predict(input req_kind_t kind, input word_t addr,
                                      input word_t wdata, input strb_t wstrb,
                                      output logic fetch);
        index_t idx;
        tag_t   tag;
        int     widx;
        int     way;
        idx   = addr[INDEX_LSB +: INDEX_WIDTH];
        tag   = addr[WORD_BITS-1 -: TAG_WIDTH];
        widx  = addr[9:2];
        way   = -1;
        fetch = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (shadow_valid[idx][w] && shadow_tag[idx][w] == tag) begin
                way = w;
            end
        end
        if (kind == REQ_WRITE) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    shadow_mem[widx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else if (way < 0) begin
            // fill goes to the lowest invalid way, else the LRU way
            fetch = 1'b1;
            way   = shadow_victim[idx];
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!shadow_valid[idx][w]) begin
                    way = w;
                end
            end
            shadow_valid[idx][way] = 1'b1;
            shadow_tag[idx][way]   = tag;
        end
        // store miss keeps the LRU bit as is
        if (way >= 0) begin
            shadow_victim[idx] = 1 - way;
        end
        return shadow_mem[widx];
    endfunction

    //////////////////////////////
    // memory model
    //////////////////////////////

    function automatic int rand_delay();
        return $random(seed) & 3;
    endfunction

    initial begin : memory_model
        logic       wr;
        word_t      addr;
        word_t      wdata;
        strb_t      wstrb;
        logic [7:0] base;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req) begin
                wr    = mem_wr;
                addr  = mem_addr;
                wdata = mem_wdata;
                wstrb = mem_wstrb;
                repeat (rand_delay()) begin
                    @(posedge clk);
                    #1;
                end
                mem_addr_ok = 1'b1;
                @(posedge clk);
                #1;
                mem_addr_ok = 1'b0;
                repeat (rand_delay()) begin
                    @(posedge clk);
                    #1;
                end
                base = addr[9:2];
                if (wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) begin
                            model_mem[base][8*b +: 8] = wdata[8*b +: 8];
                        end
                    end
                    word_writes     = word_writes + 1;
                    last_write_addr = addr;
                    last_write_data = wdata;
                    last_write_strb = wstrb;
                end else begin
                    for (int i = 0; i < LINE_WORDS; i++) begin
                        mem_rdata[i] = model_mem[8'(base + i)];
                    end
                    line_reads     = line_reads + 1;
                    last_line_addr = addr;
                end
                mem_data_ok = 1'b1;
                @(posedge clk);
                #1;
                mem_data_ok = 1'b0;
                mem_rdata   = '0;
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // one request end to end against the reference
    task automatic do_access(input req_kind_t kind, input word_t addr,
                             input word_t wdata, input strb_t wstrb);
        word_t exp_word;
        logic  exp_fetch;
        word_t got;
        exp_word = predict(kind, addr, wdata, wstrb, exp_fetch);
        @(posedge clk);
        #1;
        line_reads  = 0;
        word_writes = 0;
        req_valid   = 1'b1;
        req_kind    = kind;
        req_addr    = addr;
        req_wdata   = wdata;
        req_wstrb   = wstrb;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        @(negedge clk);
        // a read hit answers in the cycle after acceptance
        if (kind == REQ_READ && !exp_fetch) begin
            check_hit("resp_valid", resp_valid, 1'b1);
        end
        while (!resp_valid) begin
            @(negedge clk);
        end
        got = resp_rdata;
        // misses and stores answer together with mem_data_ok
        check_hit("mem_data_ok at resp_valid", mem_data_ok,
                  kind == REQ_WRITE || exp_fetch);
        check_hit("line fetch", line_reads != 0, exp_fetch);
        check_hit("memory write", word_writes != 0, kind == REQ_WRITE);
        if (kind == REQ_READ) begin
            check_word("resp_rdata", got, exp_word);
            if (exp_fetch) begin
                check_word("mem_addr", last_line_addr, {addr[31:4], 4'b0000});
            end
        end else begin
            check_mem_write(last_write_addr, last_write_data, last_write_strb,
                            {addr[31:2], 2'b00}, wdata, wstrb);
        end
    endtask

    initial begin
        word_t     addr;
        word_t     wdata;
        strb_t     wstrb;
        req_kind_t kind;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_kind  = REQ_READ;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i]  = {8'(i) ^ 8'h5a, 8'(i), ~8'(i), 8'(i) + 8'h33};
            shadow_mem[i] = model_mem[i];
        end
        for (int s = 0; s < SETS; s++) begin
            shadow_victim[s] = 0;
            for (int w = 0; w < WAYS; w++) begin
                shadow_valid[s][w] = 1'b0;
                shadow_tag[s][w]   = '0;
            end
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_hit("req_ready", req_ready, 1'b1);
        check_hit("mem_req", mem_req, 1'b0);
        check_hit("mem_wr", mem_wr, 1'b0);
        check_hit("resp_valid", resp_valid, 1'b0);

        // one fetch, then three hits in the same line
        do_access(REQ_READ, 32'h040, '0, '0);
        do_access(REQ_READ, 32'h044, '0, '0);
        do_access(REQ_READ, 32'h048, '0, '0);
        do_access(REQ_READ, 32'h04c, '0, '0);

        // store hit and read of the merged bytes
        do_access(REQ_WRITE, 32'h044, 32'hdead_beef, 4'b0101);
        do_access(REQ_READ, 32'h044, '0, '0);

        // store miss leaves the line uncached
        do_access(REQ_WRITE, 32'h300, 32'h1234_5678, 4'b1111);
        do_access(REQ_READ, 32'h300, '0, '0);

        // three tags in set 1
        do_access(REQ_READ, 32'h010, '0, '0);
        do_access(REQ_READ, 32'h110, '0, '0);
        do_access(REQ_READ, 32'h010, '0, '0);
        do_access(REQ_READ, 32'h210, '0, '0);
        do_access(REQ_READ, 32'h010, '0, '0);
        do_access(REQ_READ, 32'h110, '0, '0);

        for (int n = 0; n < RANDOM_OPS; n++) begin
            kind  = ($random(seed) & 1) ? REQ_WRITE : REQ_READ;
            addr  = $random(seed) & 32'h0000_03fc;
            wdata = $random(seed);
            wstrb = strb_t'($random(seed));
            do_access(kind, addr, wdata, wstrb);
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
